//--- sources.f
verilog/sdram_pkg.sv
verilog/sdram_fsm.sv
verilog/sdram_addr_mux.sv
verilog/sdram_dq_path.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_ctl_top.sv
testbench/sdram_model.sv
testbench/sdram_ctl_tb.sv

//--- Makefile
SRCS := $(wildcard verilog/*.sv testbench/*.sv)

.PHONY: all run clean

all: obj_dir/Vsdram_ctl_tb

obj_dir/Vsdram_ctl_tb: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module sdram_ctl_tb -f sources.f -o Vsdram_ctl_tb

run: obj_dir/Vsdram_ctl_tb
	./obj_dir/Vsdram_ctl_tb > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/sdram_ctl_tb.sv
`timescale 1ns/100ps

module sdram_ctl_tb import sdram_pkg::*; ();

    localparam int N_ACCESS = 32 + 32 + 2 + 30;
    // Init, each access at under 8 cycles, idle refresh stretch, doubled for margin
    localparam int TIMEOUT_CYCLES = 2 * (INIT_WAIT_CYCLES + N_ACCESS * 8 + 2 * REFRESH_INTERVAL);

    logic clk;
    logic rst;
    logic start;
    logic write_en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data_in;
    logic [DATA_W-1:0] data_out;
    logic data_ready;
    logic mem_ready;
    logic dram_clk;
    logic dram_cke;
    logic dram_cs_n;
    logic dram_ldqm;
    logic dram_udqm;
    logic dram_ras_n;
    logic dram_cas_n;
    logic dram_we_n;
    logic [BANK_W-1:0] dram_ba;
    logic [PIN_ADDR_W-1:0] dram_addr;
    wire [DATA_W-1:0] dram_dq;

    logic [ADDR_W-1:0] exp_addr;
    logic model_init_done;
    int model_acts;
    int model_errors;
    int errors;
    int acc_cnt;
    int cyc;
    logic [31:0] seed;
    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0] addrs [$];

    sdram_ctl_top sdram_ctl_top_i (.*);

    sdram_model sdram_model_i (
        .clk       (dram_clk),
        .rst       (rst),
        .cke       (dram_cke),
        .cs_n      (dram_cs_n),
        .dqm       ({dram_udqm, dram_ldqm}),
        .ras_n     (dram_ras_n),
        .cas_n     (dram_cas_n),
        .we_n      (dram_we_n),
        .ba        (dram_ba),
        .addr      (dram_addr),
        .dq        (dram_dq),
        .exp_addr  (exp_addr),
        .init_done (model_init_done),
        .act_count (model_acts),
        .errors    (model_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d cycles, the controller stopped responding", cyc);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
    endtask

    task automatic rule_error(input string what);
        errors++;
        $display("Check failed: %s", what);
    endtask

    // One request from strobe to return to idle, with cycle-exact checks after E0
    task automatic run_access(input logic we, input logic [ADDR_W-1:0] a,
                              input logic [DATA_W-1:0] d, input bit busy_poke, input string name);
        logic ok;
        logic [DATA_W-1:0] exp_word;
        int ret;
        ok = 1'b0;
        exp_word = we ? d : ref_mem[a];
        ret = we ? 4 : 5;
        do @(negedge clk); while (!mem_ready);
        @(posedge clk);
        start <= 1'b1;
        write_en <= we;
        addr <= a;
        data_in <= d;
        exp_addr = a;
        while (!ok) begin
            @(negedge clk);
            ok = mem_ready; // A refresh may take the edge first
            @(posedge clk);
        end
        start <= 1'b0;
        acc_cnt++;
        if (we) begin
            ref_mem[a] = d;
        end
        for (int i = 1; i <= 5; i++) begin
            @(posedge clk);
            if (busy_poke && i <= 2) begin
                start <= (i == 1);
            end
            @(negedge clk);
            assert (data_ready == (!we && i == 4))
                else value_error({name, " data_ready"}, 32'(!we && i == 4), 32'(data_ready));
            if (!we && i == 4) begin
                assert (data_out == exp_word)
                    else value_error(name, 32'(exp_word), 32'(data_out));
            end
            if (i < ret) begin
                assert (!mem_ready)
                    else rule_error({name, ": mem_ready high during the access"});
            end else if (i == ret) begin
                assert (mem_ready || sdram_ctl_top_i.refresh_due)
                    else rule_error({name, ": mem_ready did not return on time"});
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        int n;
        int idx;
        rst = 1'b0;
        start = 1'b0;
        write_en = 1'b0;
        addr = '0;
        data_in = '0;
        exp_addr = '0;
        errors = 0;
        acc_cnt = 0;
        cyc = 0;
        seed = 32'h4291_1e47;
        repeat (3) @(posedge clk);
        rst <= 1'b1;

        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (!mem_ready);
        assert (n == INIT_WAIT_CYCLES + 1 + INIT_REFRESHES * TRC_CYCLES + TMRD_CYCLES)
            else value_error("init_ready",
                32'(INIT_WAIT_CYCLES + 1 + INIT_REFRESHES * TRC_CYCLES + TMRD_CYCLES), 32'(n));
        assert (model_init_done) else rule_error("mem_ready rose before the mode register load");

        for (int i = 0; i < 32; i++) begin
            r = lcg_next();
            a = r[ADDR_W-1:0];
            r = lcg_next();
            d = r[DATA_W-1:0];
            addrs.push_back(a);
            run_access(1'b1, a, d, 1'b0, "write");
        end
        foreach (addrs[i]) begin
            run_access(1'b0, addrs[i], '0, 1'b0, "readback");
        end

        // Strobes while busy must not start another access
        r = lcg_next();
        a = r[ADDR_W-1:0];
        r = lcg_next();
        d = r[DATA_W-1:0];
        run_access(1'b1, a, d, 1'b1, "busy_write");
        run_access(1'b0, a, '0, 1'b1, "busy_read");
        addrs.push_back(a);

        for (int i = 0; i < 30; i++) begin
            r = lcg_next();
            if (r[0]) begin
                a = ADDR_W'(lcg_next() >> 7);
                d = r[31:16];
                addrs.push_back(a);
                run_access(1'b1, a, d, 1'b0, "mixed_write");
            end else begin
                idx = int'(r[8:4]) % addrs.size();
                run_access(1'b0, addrs[idx], '0, 1'b0, "mixed_read");
            end
        end

        repeat (2 * REFRESH_INTERVAL) @(posedge clk); // Idle refreshes still run
        assert (model_acts == acc_cnt) else value_error("act_count", 32'(acc_cnt), 32'(model_acts));

        $display("Errors: testbench %0d, model %0d", errors, model_errors);
        if (errors + model_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/sdram_model.sv
`timescale 1ns/100ps

module sdram_model import sdram_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cke,
    input  logic                  cs_n,
    input  logic [1:0]            dqm,
    input  logic                  ras_n,
    input  logic                  cas_n,
    input  logic                  we_n,
    input  logic [BANK_W-1:0]     ba,
    input  logic [PIN_ADDR_W-1:0] addr,
    inout  wire  [DATA_W-1:0]     dq,
    input  logic [ADDR_W-1:0]     exp_addr,
    output logic                  init_done,
    output int                    act_count,
    output int                    errors
);

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [PIN_ADDR_W-1:0] open_row [4];
    logic rd_pend;
    logic dq_en;
    logic [DATA_W-1:0] rd_word;
    logic [DATA_W-1:0] dq_out;
    int phase; // 0 waits for PRE, 1 counts init refreshes, 2 after MRS
    int nop_cnt;
    int init_refs;
    int since_ref;
    logic seen_ref;

    assign dq = dq_en ? dq_out : 'z;
    assign init_done = (phase == 2);

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
    endtask

    task automatic rule_error(input string what);
        errors++;
        $display("SDRAM protocol error: %s", what);
    endtask

    initial begin
        phase = 0;
        nop_cnt = 0;
        init_refs = 0;
        since_ref = 0;
        seen_ref = 1'b0;
        errors = 0;
        act_count = 0;
        dq_en = 1'b0;
        rd_pend = 1'b0;
        rd_word = '0;
        dq_out = '0;
    end

    always @(posedge clk) begin : decode
        sdram_cmd_t c;
        logic [ADDR_W-1:0] word_addr;
        // The pins carry no defined command until the controller has seen reset
        c = rst ? sdram_cmd_t'({ras_n, cas_n, we_n}) : CMD_NOP;
        word_addr = {ba, open_row[ba], addr[9:0]};
        // With CL2 the word goes out one edge after READ and is sampled on the next
        dq_en <= rd_pend;
        dq_out <= rd_word;
        rd_pend <= 1'b0;
        since_ref = since_ref + 1;
        assert (cke) else value_error("cke", 32'h1, 32'(cke));
        assert (!cs_n) else value_error("cs_n", 32'h0, 32'(cs_n));
        assert (dqm == 2'b00) else value_error("dqm", 32'h0, 32'(dqm));
        // A missing refresh shows up here even if no REF ever arrives
        if (phase == 2 && seen_ref) begin
            assert (since_ref <= REFRESH_INTERVAL + TRC_CYCLES + 6)
                else value_error("refresh_gap", 32'(REFRESH_INTERVAL + TRC_CYCLES + 6),
                    32'(since_ref));
        end
        if (c != CMD_NOP) begin
            assert (!seen_ref || since_ref >= TRC_CYCLES)
                else rule_error("command issued inside tRC after a refresh");
        end
        if (phase == 0) begin
            assert (c inside {CMD_NOP, CMD_PRE}) else rule_error("command before init precharge");
        end else if (phase == 1) begin
            assert (c inside {CMD_NOP, CMD_REF, CMD_MRS})
                else rule_error("access command before the mode register was loaded");
        end
        case (c)
            CMD_NOP: begin
                if (phase == 0 && rst) begin
                    nop_cnt++;
                end
            end
            CMD_PRE: begin
                if (phase == 0) begin
                    assert (nop_cnt >= INIT_WAIT_CYCLES)
                        else value_error("init_nops", 32'(INIT_WAIT_CYCLES), 32'(nop_cnt));
                    phase = 1;
                end
                assert (addr[10]) else rule_error("precharge without A10 high");
            end
            CMD_REF: begin
                if (phase == 1) begin
                    init_refs++;
                end
                seen_ref = 1'b1;
                since_ref = 0;
            end
            CMD_MRS: begin
                assert (init_refs == INIT_REFRESHES)
                    else value_error("init_refreshes", 32'(INIT_REFRESHES), 32'(init_refs));
                assert (addr == MODE_WORD) else value_error("mode_word", 32'(MODE_WORD), 32'(addr));
                assert (ba == 2'b00) else value_error("mode_bank", 32'h0, 32'(ba));
                phase = 2;
            end
            CMD_ACT: begin
                act_count++;
                assert (ba == exp_addr[24:23])
                    else value_error("act_bank", 32'(exp_addr[24:23]), 32'(ba));
                assert (addr == exp_addr[22:10])
                    else value_error("act_row", 32'(exp_addr[22:10]), 32'(addr));
                open_row[ba] = addr;
            end
            CMD_WRITE, CMD_READ: begin
                assert (ba == exp_addr[24:23])
                    else value_error("col_bank", 32'(exp_addr[24:23]), 32'(ba));
                assert (addr[9:0] == exp_addr[9:0])
                    else value_error("column", 32'(exp_addr[9:0]), 32'(addr[9:0]));
                assert (addr[10]) else rule_error("access without auto-precharge");
                if (c == CMD_WRITE) begin
                    mem[word_addr] = dq;
                end else begin
                    rd_pend <= 1'b1;
                    rd_word <= mem.exists(word_addr) ? mem[word_addr] : 16'h0000;
                end
            end
            default: begin
                rule_error("unknown command on the bus");
            end
        endcase
    end

endmodule

//--- verilog/sdram_ctl_top.sv
`timescale 1ns/100ps

module sdram_ctl_top import sdram_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  write_en,
    input  logic [ADDR_W-1:0]     addr,
    input  logic [DATA_W-1:0]     data_in,
    output logic [DATA_W-1:0]     data_out,
    output logic                  data_ready,
    output logic                  mem_ready,
    output logic                  dram_clk,
    output logic                  dram_cke,
    output logic                  dram_cs_n,
    output logic                  dram_ldqm,
    output logic                  dram_udqm,
    output logic                  dram_ras_n,
    output logic                  dram_cas_n,
    output logic                  dram_we_n,
    output logic [BANK_W-1:0]     dram_ba,
    output logic [PIN_ADDR_W-1:0] dram_addr,
    inout  wire  [DATA_W-1:0]     dram_dq
);

    mem_req_t req;
    sdram_bus_t bus;
    sdram_cmd_t cmd;
    addr_sel_t addr_sel;
    logic req_load;
    logic wr_drive;
    logic rd_issue;
    logic refresh_ack;
    logic refresh_due;

    assign req = '{write_en: write_en, addr: addr, data: data_in};

    assign dram_clk = clk; // Part runs on the controller clock
    assign dram_cke = 1'b1;
    assign dram_cs_n = 1'b0;
    assign {dram_udqm, dram_ldqm} = 2'b00; // No byte masking
    assign {dram_ras_n, dram_cas_n, dram_we_n} = bus.cmd;
    assign dram_ba = bus.ba;
    assign dram_addr = bus.addr;

    sdram_fsm sdram_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .write_en    (req.write_en),
        .refresh_due (refresh_due),
        .cmd         (cmd),
        .addr_sel    (addr_sel),
        .req_load    (req_load),
        .wr_drive    (wr_drive),
        .rd_issue    (rd_issue),
        .refresh_ack (refresh_ack),
        .mem_ready   (mem_ready)
    );

    sdram_refresh_timer sdram_refresh_timer_i (
        .clk         (clk),
        .rst         (rst),
        .refresh_ack (refresh_ack),
        .refresh_due (refresh_due)
    );

    sdram_addr_mux sdram_addr_mux_i (
        .clk      (clk),
        .rst      (rst),
        .req_load (req_load),
        .req      (req),
        .cmd      (cmd),
        .addr_sel (addr_sel),
        .bus      (bus)
    );

    sdram_dq_path sdram_dq_path_i (
        .clk        (clk),
        .rst        (rst),
        .req_load   (req_load),
        .data_in    (req.data),
        .wr_drive   (wr_drive),
        .rd_issue   (rd_issue),
        .dq         (dram_dq),
        .data_out   (data_out),
        .data_ready (data_ready)
    );

endmodule

//--- verilog/sdram_refresh_timer.sv
`timescale 1ns/100ps

module sdram_refresh_timer import sdram_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic refresh_ack,
    output logic refresh_due
);

    logic [REFRESH_W-1:0] count;

    // The interval is measured from each acknowledged refresh
    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= REFRESH_W'(REFRESH_INTERVAL - 1);
            refresh_due <= 1'b0;
        end else if (refresh_ack) begin
            count <= REFRESH_W'(REFRESH_INTERVAL - 1);
            refresh_due <= 1'b0;
        end else if (count == '0) begin
            refresh_due <= 1'b1; // Held until the controller gets to it
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

//--- verilog/sdram_dq_path.sv
`timescale 1ns/100ps

module sdram_dq_path import sdram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_load,
    input  logic [DATA_W-1:0] data_in,
    input  logic              wr_drive,
    input  logic              rd_issue,
    inout  wire  [DATA_W-1:0] dq,
    output logic [DATA_W-1:0] data_out,
    output logic              data_ready
);

    logic [DATA_W-1:0] wr_data;
    logic drive_en;
    logic [CAS_LATENCY:0] rd_pipe;

    // Bus is driven only while the WRITE command is on the pins
    assign dq = drive_en ? wr_data : 'z;

    always_ff @(posedge clk) begin
        if (req_load) begin
            wr_data <= data_in;
        end
        if (rd_pipe[CAS_LATENCY]) begin
            data_out <= dq;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            drive_en <= 1'b0;
            rd_pipe <= '0;
            data_ready <= 1'b0;
        end else begin
            drive_en <= wr_drive;
            // One stage for the READ command itself plus the CAS latency
            rd_pipe <= {rd_pipe[CAS_LATENCY-1:0], rd_issue};
            data_ready <= rd_pipe[CAS_LATENCY];
        end
    end

endmodule

//--- verilog/sdram_addr_mux.sv
`timescale 1ns/100ps

module sdram_addr_mux import sdram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_load,
    input  mem_req_t   req,
    input  sdram_cmd_t cmd,
    input  addr_sel_t  addr_sel,
    output sdram_bus_t bus
);

    logic [ADDR_W-1:0] addr_r;

    always_ff @(posedge clk) begin
        if (!rst) begin
            addr_r <= '0;
        end else if (req_load) begin
            addr_r <= req.addr;
        end
    end

    // Bank is addr[24:23], row addr[22:10], column addr[9:0]
    always_comb begin
        bus.cmd = cmd;
        case (addr_sel)
            ADDR_PRE_ALL: begin
                bus.ba = '0;
                bus.addr = PRE_ALL_WORD;
            end
            ADDR_MODE: begin
                bus.ba = '0;
                bus.addr = MODE_WORD;
            end
            ADDR_ROW: begin
                bus.ba = addr_r[24:23];
                bus.addr = addr_r[22:10];
            end
            default: begin
                bus.ba = addr_r[24:23];
                bus.addr = {2'b00, 1'b1, addr_r[9:0]}; // A10 requests auto-precharge
            end
        endcase
    end

endmodule

//--- verilog/sdram_fsm.sv
`timescale 1ns/100ps

module sdram_fsm import sdram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       write_en,
    input  logic       refresh_due,
    output sdram_cmd_t cmd,
    output addr_sel_t  addr_sel,
    output logic       req_load,
    output logic       wr_drive,
    output logic       rd_issue,
    output logic       refresh_ack,
    output logic       mem_ready
);

    fsm_state_t state;
    logic [WAIT_W-1:0] wait_cnt;
    logic [REF_CNT_W-1:0] refs_left;

    // A pending refresh holds off new requests, so start is never dropped while ready
    assign mem_ready = (state == ST_IDLE) && !refresh_due;
    assign req_load = mem_ready && start;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_INIT_WAIT;
            wait_cnt <= WAIT_W'(INIT_WAIT_CYCLES - 1);
            refs_left <= '0;
            cmd <= CMD_NOP;
            addr_sel <= ADDR_PRE_ALL;
            wr_drive <= 1'b0;
            rd_issue <= 1'b0;
            refresh_ack <= 1'b0;
        end else begin
            // Commands and strobes last one cycle unless a state sets them again
            cmd <= CMD_NOP;
            wr_drive <= 1'b0;
            rd_issue <= 1'b0;
            refresh_ack <= 1'b0;
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end

            case (state)
                ST_INIT_WAIT: begin
                    if (wait_cnt == '0) begin
                        cmd <= CMD_PRE;
                        addr_sel <= ADDR_PRE_ALL;
                        state <= ST_INIT_PRE;
                    end
                end
                ST_INIT_PRE: begin
                    cmd <= CMD_REF;
                    refresh_ack <= 1'b1; // Init refreshes also restart the interval
                    refs_left <= REF_CNT_W'(INIT_REFRESHES - 1);
                    wait_cnt <= WAIT_W'(TRC_CYCLES - 1);
                    state <= ST_INIT_REF;
                end
                ST_INIT_REF: begin
                    if (wait_cnt == '0) begin
                        if (refs_left != '0) begin
                            cmd <= CMD_REF;
                            refresh_ack <= 1'b1;
                            refs_left <= refs_left - 1'b1;
                            wait_cnt <= WAIT_W'(TRC_CYCLES - 1);
                        end else begin
                            cmd <= CMD_MRS;
                            addr_sel <= ADDR_MODE;
                            wait_cnt <= WAIT_W'(TMRD_CYCLES - 1);
                            state <= ST_INIT_MRS;
                        end
                    end
                end
                ST_INIT_MRS: begin
                    if (wait_cnt == '0) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (refresh_due) begin
                        cmd <= CMD_REF;
                        refresh_ack <= 1'b1;
                        wait_cnt <= WAIT_W'(TRC_CYCLES - 1);
                        state <= ST_REFRESH;
                    end else if (start) begin
                        cmd <= CMD_ACT;
                        addr_sel <= ADDR_ROW;
                        wr_drive <= write_en;
                        rd_issue <= !write_en;
                        state <= ST_ACTIVATE;
                    end
                end
                ST_REFRESH: begin
                    if (wait_cnt == '0) begin
                        state <= ST_IDLE;
                    end
                end
                ST_ACTIVATE: begin
                    addr_sel <= ADDR_COL;
                    // wr_drive is high only in this cycle of a write access
                    if (wr_drive) begin
                        cmd <= CMD_WRITE;
                        state <= ST_WRITE;
                    end else begin
                        cmd <= CMD_READ;
                        state <= ST_READ;
                    end
                end
                ST_WRITE: begin
                    wait_cnt <= WAIT_W'(WR_RECOVER_CYCLES - 1);
                    state <= ST_RECOVER;
                end
                ST_READ: begin
                    wait_cnt <= WAIT_W'(RD_RECOVER_CYCLES - 1); // Covers the CAS delay too
                    state <= ST_RECOVER;
                end
                ST_RECOVER: begin
                    if (wait_cnt == '0) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_INIT_WAIT;
                end
            endcase
        end
    end

endmodule

//--- verilog/sdram_pkg.sv
package sdram_pkg;

    // Word and address geometry of the part
    localparam int DATA_W = 16;
    localparam int ADDR_W = 25;
    localparam int BANK_W = 2;
    localparam int PIN_ADDR_W = 13;

    localparam int INIT_WAIT_CYCLES = 5000; // 100 us at 50 MHz
    localparam int INIT_REFRESHES = 2;
    localparam int TRC_CYCLES = 8;
    localparam int TMRD_CYCLES = 2;
    localparam int CAS_LATENCY = 2;
    localparam int REFRESH_INTERVAL = 390; // 7.8 us per row at 50 MHz

    // Cycles from the READ or WRITE edge back to idle, tWR plus tRP with auto-precharge
    localparam int WR_RECOVER_CYCLES = 2;
    localparam int RD_RECOVER_CYCLES = 3;

    localparam int WAIT_W = $clog2(INIT_WAIT_CYCLES);
    localparam int REFRESH_W = $clog2(REFRESH_INTERVAL);
    localparam int REF_CNT_W = $clog2(INIT_REFRESHES) + 1;

    // Burst length 1, sequential, CAS latency 2, programmed burst writes
    localparam logic [PIN_ADDR_W-1:0] MODE_WORD = 13'b000_0_00_010_0_000;
    localparam logic [PIN_ADDR_W-1:0] PRE_ALL_WORD = 13'h0400; // A10 selects all banks

    // Encoded as {ras_n, cas_n, we_n}
    typedef enum logic [2:0] {
        CMD_MRS   = 3'b000,
        CMD_REF   = 3'b001,
        CMD_PRE   = 3'b010,
        CMD_ACT   = 3'b011,
        CMD_WRITE = 3'b100,
        CMD_READ  = 3'b101,
        CMD_NOP   = 3'b111
    } sdram_cmd_t;

    typedef enum logic [1:0] {
        ADDR_PRE_ALL,
        ADDR_MODE,
        ADDR_ROW,
        ADDR_COL
    } addr_sel_t;

    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_INIT_PRE,
        ST_INIT_REF,
        ST_INIT_MRS,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_WRITE,
        ST_READ,
        ST_RECOVER
    } fsm_state_t;

    typedef struct packed {
        logic              write_en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        sdram_cmd_t            cmd;
        logic [BANK_W-1:0]     ba;
        logic [PIN_ADDR_W-1:0] addr;
    } sdram_bus_t;

endpackage
